// ==== Bender.yml ====
package:
  name: z8Soc

sources:
  - verilog/z8Pkg.sv
  - verilog/programRom.sv
  - verilog/instrDecoder.sv
  - verilog/registerFile.sv
  - verilog/alu.sv
  - verilog/sequencer.sv
  - verilog/z8Soc.sv
  - target: test
    files:
      - tests/z8SocTb.sv

// ==== tb.f ====
verilog/z8Pkg.sv
verilog/programRom.sv
verilog/instrDecoder.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/sequencer.sv
verilog/z8Soc.sv
tests/z8SocTb.sv

// ==== tests/z8SocTb.sv ====
`default_nettype none

module z8SocTb;

    logic clk;
    logic rstN;
    z8Pkg::romLoadT load;
    logic start;
    z8Pkg::retireT retire;

    z8Pkg::romLoadT progQ[$];
    z8Pkg::retireT expQ[$];

    int errors = 0;
    int cycles = 0;
    int limit = 0;
    int checked = 0;
    int seed;
    int idle;
    bit traceOk;

    z8Soc #(.romAddrBits(12)) dut (
        .clk(clk),
        .rstN(rstN),
        .load(load),
        .start(start),
        .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Trace lines hold P program records and E expected retire records
    task automatic readTrace(output bit ok);
        int fd;
        int n;
        logic [63:0] tag;
        logic [1023:0] line;
        logic [15:0] addr;
        logic [7:0] data;
        logic [7:0] we;
        logic [7:0] wa;
        logic [7:0] wd;
        logic [7:0] fl;
        z8Pkg::romLoadT rec;
        z8Pkg::retireT exp;
        ok = 1'b0;
        fd = $fopen("tests/z8Trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "P") begin
                    n = $fscanf(fd, "%h %h", addr, data);
                    if (n != 2) begin
                        ok = 1'b0;
                    end
                    rec.valid = 1'b1;
                    rec.addr = addr;
                    rec.data = data;
                    progQ.push_back(rec);
                end else if (tag == "E") begin
                    n = $fscanf(fd, "%h %h %h %h %h", addr, we, wa, wd, fl);
                    if (n != 5) begin
                        ok = 1'b0;
                    end
                    exp.valid = 1'b1;
                    exp.pc = addr;
                    exp.wrEn = we[0];
                    exp.wrAddr = wa;
                    exp.wrData = wd;
                    exp.flags = z8Pkg::flagsT'(fl);
                    expQ.push_back(exp);
                end else begin
                    // Comment line
                    n = $fgets(line, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic reportMismatch(input string field, input logic [15:0] expVal,
                                  input logic [15:0] gotVal);
        $display("mismatch at time %0t: retire %0d %s expected %h got %h",
                 $time, checked, field, expVal, gotVal);
        errors++;
    endtask

    // Compare each retire strobe with the next expected record
    always @(negedge clk) begin
        if (rstN && retire.valid) begin
            if (checked >= expQ.size()) begin
                $display("Unexpected retire at pc %h after the end of the trace", retire.pc);
                errors++;
            end else begin
                if (retire.pc != expQ[checked].pc) begin
                    reportMismatch("pc", expQ[checked].pc, retire.pc);
                end
                if (retire.wrEn != expQ[checked].wrEn) begin
                    reportMismatch("wrEn", 16'(expQ[checked].wrEn), 16'(retire.wrEn));
                end
                if (expQ[checked].wrEn && retire.wrAddr != expQ[checked].wrAddr) begin
                    reportMismatch("wrAddr", 16'(expQ[checked].wrAddr), 16'(retire.wrAddr));
                end
                if (expQ[checked].wrEn && retire.wrData != expQ[checked].wrData) begin
                    reportMismatch("wrData", 16'(expQ[checked].wrData), 16'(retire.wrData));
                end
                if (retire.flags != expQ[checked].flags) begin
                    reportMismatch("flags", 16'(expQ[checked].flags), 16'(retire.flags));
                end
                checked++;
            end
        end
    end

    // Missing retires end up here
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, only %0d of %0d retires seen",
                     cycles, checked, expQ.size());
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        seed = 38220;
        rstN = 1'b0;
        start = 1'b0;
        load = '0;
        readTrace(traceOk);
        if (!traceOk) begin
            $display("Could not read the trace file tests/z8Trace.txt");
            $display("Verification failed");
            $finish;
        end else begin
            limit = 10 * expQ.size() + progQ.size() + 50;
            repeat (10) @(negedge clk);
            rstN = 1'b1;

            foreach (progQ[i]) begin
                idle = $unsigned($random(seed)) % 2;
                repeat (idle) begin
                    @(negedge clk);
                    load = '0;
                end
                @(negedge clk);
                load = progQ[i];
            end
            @(negedge clk);
            load = '0;
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;

            wait (checked == expQ.size());
            @(negedge clk);
            $display("Checked %0d retires, %0d errors", checked, errors);
            if (errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/z8Trace.txt ====
# P addr byte : program byte loaded into the ROM
# E pc wrEn wrAddr wrData flags : expected retire, flags as C Z S V in bits 7 to 4
P 000C 31
P 000D 10
P 000E 3C
P 000F 5A
P 0010 0C
P 0011 7F
P 0012 1C
P 0013 01
P 0014 02
P 0015 01
P 0016 12
P 0017 01
P 0018 06
P 0019 E3
P 001A F0
P 001B 16
P 001C E3
P 001D 05
P 001E 22
P 001F 30
P 0020 36
P 0021 E1
P 0022 00
P 0023 42
P 0024 01
P 0025 56
P 0026 E0
P 0027 0F
P 0028 B2
P 0029 30
P 002A A2
P 002B 03
P 002C 76
P 002D E3
P 002E C0
P 002F 66
P 0030 E3
P 0031 31
P 0032 62
P 0033 31
P 0034 20
P 0035 E0
P 0036 00
P 0037 E0
P 0038 10
P 0039 E3
P 003A C0
P 003B E3
P 003C D0
P 003D E3
P 003E E0
P 003F E3
P 0040 90
P 0041 E0
P 0042 60
P 0043 E3
P 0044 F0
P 0045 E3
P 0046 B0
P 0047 E3
P 0048 DF
P 0049 7B
P 004A 02
P 004D EF
P 004E 7B
P 004F 02
P 0050 FB
P 0051 02
P 0054 CF
P 0055 2C
P 0056 03
P 0057 20
P 0058 E0
P 0059 2A
P 005A FC
P 005B 6D
P 005C 00
P 005D 70
P 005E ED
P 005F 00
P 0060 70
P 0070 04
P 0071 11
P 0072 22
P 0073 FF
P 0074 8B
P 0075 FE
E 000C 1 FD 10 00
E 000E 1 13 5A 00
E 0010 1 10 7F 00
E 0012 1 11 01 00
E 0014 1 10 80 30
E 0016 1 10 81 20
E 0018 1 13 4A 80
E 001B 1 13 50 00
E 001E 1 13 CF B0
E 0020 1 11 00 40
E 0023 1 10 81 20
E 0025 1 10 01 00
E 0028 1 13 CE 20
E 002A 0 00 00 80
E 002C 0 00 00 A0
E 002F 0 00 00 80
E 0032 0 00 00 C0
E 0034 1 10 02 80
E 0036 1 10 01 80
E 0038 1 13 9D A0
E 003A 1 13 CE A0
E 003C 1 13 E7 20
E 003E 1 13 F3 A0
E 0040 1 10 02 00
E 0042 1 13 0C 00
E 0044 1 13 C0 20
E 0046 1 13 00 20
E 0048 0 00 00 A0
E 0049 0 00 00 A0
E 004D 0 00 00 20
E 004E 0 00 00 20
E 0050 0 00 00 20
E 0054 0 00 00 20
E 0055 1 12 03 20
E 0057 1 10 03 00
E 0059 1 12 02 00
E 0057 1 10 04 00
E 0059 1 12 01 00
E 0057 1 10 05 00
E 0059 1 12 00 00
E 005B 0 00 00 00
E 005E 0 00 00 00
E 0070 0 00 00 00
E 0073 0 00 00 00
E 0074 0 00 00 00

// ==== verilog/alu.sv ====
`default_nettype none

module alu (
    input  wire z8Pkg::aluOpE op,
    input  wire logic [7:0]   a,
    input  wire logic [7:0]   b,
    input  wire z8Pkg::flagsT flagsIn,
    output logic [7:0]        result,
    output z8Pkg::flagsT      flagsOut
);
    logic [8:0] sum;
    logic carryIn;

    assign carryIn = flagsIn.c;

    always_comb begin
        result = a;
        flagsOut = flagsIn;
        sum = 9'h000;
        case (op)
            z8Pkg::ALU_ADD, z8Pkg::ALU_ADC: begin
                sum = {1'b0, a} + {1'b0, b} + {8'h00, (op == z8Pkg::ALU_ADC) & carryIn};
                result = sum[7:0];
                flagsOut.c = sum[8];
                flagsOut.v = (a[7] == b[7]) && (result[7] != a[7]);
            end
            z8Pkg::ALU_SUB, z8Pkg::ALU_SBC, z8Pkg::ALU_CP: begin
                // sum[8] ends up as the borrow
                sum = {1'b0, a} - {1'b0, b} - {8'h00, (op == z8Pkg::ALU_SBC) & carryIn};
                result = sum[7:0];
                flagsOut.c = sum[8];
                flagsOut.v = (a[7] != b[7]) && (result[7] != a[7]);
            end
            z8Pkg::ALU_OR: begin
                result = a | b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::ALU_AND, z8Pkg::ALU_TM: begin
                result = a & b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::ALU_XOR: begin
                result = a ^ b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::ALU_TCM: begin
                result = ~a & b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::ALU_INC: begin
                result = a + 8'd1;
                flagsOut.v = (result == 8'h80);
            end
            z8Pkg::ALU_DEC: begin
                result = a - 8'd1;
                flagsOut.v = (result == 8'h7F);
            end
            z8Pkg::ALU_COM: begin
                result = ~a;
                flagsOut.v = 1'b0;
            end
            z8Pkg::ALU_CLR: result = 8'h00;
            z8Pkg::ALU_RLC, z8Pkg::ALU_RL: begin
                result = {a[6:0], (op == z8Pkg::ALU_RLC) ? carryIn : a[7]};
                flagsOut.c = a[7];
                flagsOut.v = result[7] ^ a[7];
            end
            z8Pkg::ALU_RRC, z8Pkg::ALU_RR, z8Pkg::ALU_SRA: begin
                case (op)
                    z8Pkg::ALU_RRC: result = {carryIn, a[7:1]};
                    z8Pkg::ALU_RR: result = {a[0], a[7:1]};
                    default: result = {a[7], a[7:1]};
                endcase
                flagsOut.c = a[0];
                flagsOut.v = result[7] ^ a[7];
            end
            z8Pkg::ALU_SWAP: result = {a[3:0], a[7:4]};
            default: result = a;
        endcase

        // clr and ld leave every flag alone
        if (!(op inside {z8Pkg::ALU_CLR, z8Pkg::ALU_LD})) begin
            flagsOut.z = (result == 8'h00);
            flagsOut.s = result[7];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`default_nettype none

module instrDecoder (
    input  wire logic [7:0] opcode,
    output z8Pkg::decodedT  decoded
);
    logic [3:0] hi;
    logic [3:0] lo;

    assign hi = opcode[7:4];
    assign lo = opcode[3:0];

    always_comb begin
        decoded.cond = hi;
        if (lo inside {4'hE, 4'hF}) begin
            decoded.instrLen = 2'd1;
        end else if (lo inside {[4'h4:4'h7], 4'hD}) begin
            decoded.instrLen = 2'd3;
        end else begin
            decoded.instrLen = 2'd2;
        end

        decoded.cls = z8Pkg::NOP;
        decoded.aluOp = z8Pkg::ALU_LD;
        decoded.writesDst = 1'b0;
        case (lo)
            4'h0: begin
                if (hi inside {4'h0, 4'h1, 4'h2, 4'h6, 4'h9, [4'hB:4'hF]}) begin
                    decoded.cls = z8Pkg::ALU1_R;
                    decoded.aluOp = z8Pkg::aluOpE'({1'b0, hi});
                    decoded.writesDst = 1'b1;
                end
            end
            4'h1: begin
                if (hi == 4'h3) begin
                    decoded.cls = z8Pkg::SRP;
                    decoded.writesDst = 1'b1;
                end
            end
            4'h2, 4'h6: begin
                if (hi inside {[4'h0:4'h7], 4'hA, 4'hB}) begin
                    decoded.cls = lo[2] ? z8Pkg::ALU2_RIM : z8Pkg::ALU2_RR;
                    decoded.aluOp = z8Pkg::aluOpE'({1'b1, hi});
                    // tcm, tm and cp only touch the flags
                    decoded.writesDst = !(hi inside {4'h6, 4'h7, 4'hA});
                end
            end
            4'hA: begin
                decoded.cls = z8Pkg::DJNZ;
                decoded.aluOp = z8Pkg::ALU_DEC;
                decoded.writesDst = 1'b1;
            end
            4'hB: decoded.cls = z8Pkg::JR;
            4'hC: begin
                decoded.cls = z8Pkg::LD_RIM;
                decoded.writesDst = 1'b1;
            end
            4'hD: decoded.cls = z8Pkg::JP;
            4'hF: begin
                if (hi inside {4'hC, 4'hD, 4'hE}) begin
                    decoded.cls = z8Pkg::FLAGOP;
                end
            end
            default: decoded.cls = z8Pkg::NOP;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/programRom.sv ====
`default_nettype none

module programRom #(
    parameter int romAddrBits = 12
) (
    input  wire logic           clk,
    input  wire z8Pkg::romLoadT load,
    input  wire logic           fetchEn,
    input  wire z8Pkg::addrT    fetchAddr,
    output logic [7:0]          romData
);
    logic [7:0] mem [2**romAddrBits];

    always_ff @(posedge clk) begin
        if (load.valid) begin
            mem[load.addr[romAddrBits-1:0]] <= load.data;
        end
        // Upper address bits are ignored
        if (fetchEn) begin
            romData <= mem[fetchAddr[romAddrBits-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/registerFile.sv ====
`default_nettype none

module registerFile (
    input  wire logic           clk,
    input  wire logic           rstN,
    input  wire z8Pkg::regAddrT rdAddrA,
    input  wire z8Pkg::regAddrT rdAddrB,
    output logic [7:0]          rdDataA,
    output logic [7:0]          rdDataB,
    input  wire logic           wrEn,
    input  wire z8Pkg::regAddrT wrAddr,
    input  wire logic [7:0]     wrData,
    input  wire logic           flagWrEn,
    input  wire z8Pkg::flagsT   flagsIn,
    output z8Pkg::flagsT        flags,
    output z8Pkg::regAddrT      resolvedWrAddr
);
    logic [7:0] regs [128];
    logic [3:0] rp;
    z8Pkg::flagsT flagReg;
    z8Pkg::regAddrT mapA;
    z8Pkg::regAddrT mapB;
    z8Pkg::regAddrT mapW;

    // Working registers Ex live at the register pointer
    function automatic z8Pkg::regAddrT mapAddr(input z8Pkg::regAddrT addr,
                                               input logic [3:0] ptr);
        return (addr[7:4] == 4'hE) ? {ptr, addr[3:0]} : addr;
    endfunction

    function automatic logic [7:0] readReg(input z8Pkg::regAddrT addr);
        logic [7:0] value;
        if (!addr[7]) begin
            value = regs[addr[6:0]];
        end else if (addr == z8Pkg::FLAGS_REG) begin
            value = flagReg;
        end else if (addr == z8Pkg::RP_REG) begin
            value = {rp, 4'h0};
        end else begin
            value = 8'h00;
        end
        return value;
    endfunction

    assign mapA = mapAddr(rdAddrA, rp);
    assign mapB = mapAddr(rdAddrB, rp);
    assign mapW = mapAddr(wrAddr, rp);

    always_comb begin
        rdDataA = readReg(mapA);
        rdDataB = readReg(mapB);
    end

    always_ff @(posedge clk) begin
        if (wrEn && !mapW[7]) begin
            regs[mapW[6:0]] <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flagReg <= '0;
            rp <= 4'h0;
        end else begin
            // Explicit write to FC wins over the ALU flags
            if (wrEn && mapW == z8Pkg::FLAGS_REG) begin
                flagReg <= z8Pkg::flagsT'({wrData[7:4], 4'h0});
            end else if (flagWrEn) begin
                flagReg <= flagsIn;
            end
            if (wrEn && mapW == z8Pkg::RP_REG) begin
                rp <= wrData[7:4];
            end
        end
    end

    assign flags = flagReg;
    assign resolvedWrAddr = mapW;

endmodule

`default_nettype wire

// ==== verilog/sequencer.sv ====
`default_nettype none

module sequencer (
    input  wire logic           clk,
    input  wire logic           rstN,
    input  wire logic           start,
    output logic                fetchEn,
    output z8Pkg::addrT         fetchAddr,
    input  wire logic [7:0]     romData,
    output logic [7:0]          opcode,
    input  wire z8Pkg::decodedT decoded,
    output z8Pkg::regAddrT      rdAddrA,
    output z8Pkg::regAddrT      rdAddrB,
    input  wire logic [7:0]     rdDataA,
    input  wire logic [7:0]     rdDataB,
    input  wire z8Pkg::flagsT   regFlags,
    input  wire z8Pkg::regAddrT resolvedWrAddr,
    output z8Pkg::aluOpE        aluOp,
    output logic [7:0]          aluA,
    output logic [7:0]          aluB,
    input  wire logic [7:0]     aluResult,
    input  wire z8Pkg::flagsT   aluFlags,
    output logic                wrEn,
    output z8Pkg::regAddrT      wrAddr,
    output logic [7:0]          wrData,
    output logic                flagWrEn,
    output z8Pkg::flagsT        flagsIn,
    output z8Pkg::retireT       retire
);
    typedef enum logic [3:0] {
        S_IDLE,
        S_FETCH_OP,
        S_CAP_OP,
        S_FETCH_2,
        S_CAP_2,
        S_FETCH_3,
        S_CAP_3,
        S_EXEC,
        S_DJNZ
    } stateE;

    stateE state;
    z8Pkg::addrT pc;
    z8Pkg::addrT instrPc;
    z8Pkg::addrT relTarget;
    logic [7:0] opReg;
    logic [7:0] second;
    logic [7:0] third;
    logic execute;
    logic retiring;
    logic condBase;
    logic takeBranch;
    z8Pkg::retireT retireQ;

    assign execute = (state == S_EXEC);
    assign fetchEn = state inside {S_FETCH_OP, S_FETCH_2, S_FETCH_3};
    assign fetchAddr = pc;
    // Decode straight off the ROM while the opcode is captured
    assign opcode = (state == S_CAP_OP) ? romData : opReg;

    always_comb begin
        case (decoded.cond[2:0])
            3'd0: condBase = 1'b0;
            3'd1: condBase = regFlags.s ^ regFlags.v;
            3'd2: condBase = (regFlags.s ^ regFlags.v) | regFlags.z;
            3'd3: condBase = regFlags.c | regFlags.z;
            3'd4: condBase = regFlags.v;
            3'd5: condBase = regFlags.s;
            3'd6: condBase = regFlags.z;
            default: condBase = regFlags.c;
        endcase
    end

    assign takeBranch = condBase ^ decoded.cond[3];
    // pc already points past the instruction here
    assign relTarget = pc + {{8{second[7]}}, second};

    always_comb begin
        case (decoded.cls)
            z8Pkg::ALU2_RR: rdAddrA = {4'hE, second[7:4]};
            z8Pkg::LD_RIM, z8Pkg::DJNZ: rdAddrA = {4'hE, opReg[7:4]};
            z8Pkg::SRP: rdAddrA = z8Pkg::RP_REG;
            default: rdAddrA = second;
        endcase
    end

    assign rdAddrB = {4'hE, second[3:0]};
    assign aluOp = decoded.aluOp;
    assign aluA = (decoded.cls inside {z8Pkg::LD_RIM, z8Pkg::SRP}) ? second : rdDataA;
    assign aluB = (decoded.cls == z8Pkg::ALU2_RIM) ? third : rdDataB;

    assign wrEn = execute && decoded.writesDst;
    assign wrAddr = rdAddrA;
    assign wrData = aluResult;
    assign flagWrEn = execute && (decoded.cls inside {z8Pkg::ALU1_R, z8Pkg::ALU2_RR,
                                                      z8Pkg::ALU2_RIM, z8Pkg::FLAGOP});

    always_comb begin
        flagsIn = aluFlags;
        if (decoded.cls == z8Pkg::FLAGOP) begin
            flagsIn = regFlags;
            // CF clears, DF sets, EF flips the carry
            flagsIn.c = opReg[5] ? ~regFlags.c : opReg[4];
        end
    end

    assign retiring = (execute && decoded.cls != z8Pkg::DJNZ) || state == S_DJNZ;

    always_comb begin
        retire = retireQ;
        // Writes have landed by the time the strobe is out
        retire.flags = regFlags;
    end

    always_ff @(posedge clk) begin
        case (state)
            S_FETCH_OP: instrPc <= pc;
            S_CAP_OP: opReg <= romData;
            S_CAP_2: second <= romData;
            S_CAP_3: third <= romData;
            default: opReg <= opReg;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= S_IDLE;
            pc <= z8Pkg::RESET_PC;
            retireQ <= '0;
        end else begin
            retireQ.valid <= retiring;
            if (retiring) begin
                retireQ.pc <= instrPc;
                retireQ.wrEn <= wrEn || state == S_DJNZ;
                retireQ.wrAddr <= resolvedWrAddr;
                retireQ.wrData <= (state == S_DJNZ) ? rdDataA : wrData;
            end

            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_FETCH_OP;
                        pc <= z8Pkg::RESET_PC;
                    end
                end
                S_FETCH_OP, S_FETCH_2, S_FETCH_3: begin
                    pc <= pc + 16'd1;
                    state <= stateE'(state + 4'd1);
                end
                S_CAP_OP: state <= (decoded.instrLen == 2'd1) ? S_EXEC : S_FETCH_2;
                S_CAP_2: state <= (decoded.instrLen == 2'd2) ? S_EXEC : S_FETCH_3;
                S_CAP_3: state <= S_EXEC;
                S_EXEC: begin
                    state <= (decoded.cls == z8Pkg::DJNZ) ? S_DJNZ : S_FETCH_OP;
                    if (takeBranch && decoded.cls == z8Pkg::JR) begin
                        pc <= relTarget;
                    end
                    if (takeBranch && decoded.cls == z8Pkg::JP) begin
                        pc <= {second, third};
                    end
                end
                S_DJNZ: begin
                    // Decremented count is back in the register file
                    state <= S_FETCH_OP;
                    if (rdDataA != 8'h00) begin
                        pc <= relTarget;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/z8Pkg.sv ====
`default_nettype none

package z8Pkg;

    typedef logic [15:0] addrT;
    typedef logic [7:0] regAddrT;

    // One-operand ops sit at the opcode high nibble, two-operand ops at 0x10 plus it
    typedef enum logic [4:0] {
        ALU_DEC  = 5'h00,
        ALU_RLC  = 5'h01,
        ALU_INC  = 5'h02,
        ALU_LD   = 5'h03,
        ALU_COM  = 5'h06,
        ALU_RL   = 5'h09,
        ALU_CLR  = 5'h0B,
        ALU_RRC  = 5'h0C,
        ALU_SRA  = 5'h0D,
        ALU_RR   = 5'h0E,
        ALU_SWAP = 5'h0F,
        ALU_ADD  = 5'h10,
        ALU_ADC  = 5'h11,
        ALU_SUB  = 5'h12,
        ALU_SBC  = 5'h13,
        ALU_OR   = 5'h14,
        ALU_AND  = 5'h15,
        ALU_TCM  = 5'h16,
        ALU_TM   = 5'h17,
        ALU_CP   = 5'h1A,
        ALU_XOR  = 5'h1B
    } aluOpE;

    typedef enum logic [3:0] {
        ALU1_R,
        ALU2_RR,
        ALU2_RIM,
        LD_RIM,
        DJNZ,
        JR,
        JP,
        SRP,
        FLAGOP,
        NOP
    } instrClassE;

    typedef struct packed {
        logic [1:0] instrLen;
        instrClassE cls;
        aluOpE      aluOp;
        logic       writesDst;
        logic [3:0] cond;
    } decodedT;

    // Same bit order as the control register at FC
    typedef struct packed {
        logic       c;
        logic       z;
        logic       s;
        logic       v;
        logic [3:0] unused;
    } flagsT;

    typedef struct packed {
        logic       valid;
        addrT       addr;
        logic [7:0] data;
    } romLoadT;

    typedef struct packed {
        logic       valid;
        addrT       pc;
        logic       wrEn;
        regAddrT    wrAddr;
        logic [7:0] wrData;
        flagsT      flags;
    } retireT;

    localparam addrT RESET_PC = 16'h000C;
    localparam regAddrT FLAGS_REG = 8'hFC;
    localparam regAddrT RP_REG = 8'hFD;

endpackage

`default_nettype wire

// ==== verilog/z8Soc.sv ====
`default_nettype none

module z8Soc #(
    parameter int romAddrBits = 12
) (
    input  wire logic           clk,
    input  wire logic           rstN,
    input  wire z8Pkg::romLoadT load,
    input  wire logic           start,
    output z8Pkg::retireT       retire
);
    logic fetchEn;
    z8Pkg::addrT fetchAddr;
    logic [7:0] romData;
    logic [7:0] opcode;
    z8Pkg::decodedT decoded;
    z8Pkg::regAddrT rdAddrA;
    z8Pkg::regAddrT rdAddrB;
    logic [7:0] rdDataA;
    logic [7:0] rdDataB;
    z8Pkg::flagsT regFlags;
    z8Pkg::regAddrT resolvedWrAddr;
    z8Pkg::aluOpE aluOp;
    logic [7:0] aluA;
    logic [7:0] aluB;
    logic [7:0] aluResult;
    z8Pkg::flagsT aluFlags;
    logic wrEn;
    z8Pkg::regAddrT wrAddr;
    logic [7:0] wrData;
    logic flagWrEn;
    z8Pkg::flagsT flagsIn;

    programRom #(.romAddrBits(romAddrBits)) rom (.*);

    instrDecoder decoder (.*);

    registerFile regFile (
        .*,
        .flags(regFlags)
    );

    alu aluUnit (
        .op(aluOp),
        .a(aluA),
        .b(aluB),
        .flagsIn(regFlags),
        .result(aluResult),
        .flagsOut(aluFlags)
    );

    sequencer seq (.*);

endmodule

`default_nettype wire
